/* source/mapperPkg.sv */
`default_nettype none

package mapperPkg;

	// Map and screen geometry
	localparam int MapW = 320;
	localparam int MapH = 240;
	localparam int TexelShift = 2;
	localparam int SpriteX0 = 311;
	localparam int SpriteY0 = 340;
	localparam int SpriteW = 19;
	localparam int SpriteH = 29;
	localparam int SheetW = 228;

	// Camera start and limits
	localparam int CamStartX = 100;
	localparam int CamStartY = 100;
	localparam int CamMinX = -311;
	localparam int CamMaxX = 951;
	localparam int CamMinY = -340;
	localparam int CamMaxY = 594;
	localparam int StepDelay = 8;

	localparam int CoordW = 11;
	localparam int CamW = 13;
	localparam int MapAddrW = 17;
	localparam int SpriteAddrW = 13;

	// Same coding as the direction input
	typedef enum logic [1:0] {
		dirUp = 2'd0,
		dirRight = 2'd1,
		dirDown = 2'd2,
		dirLeft = 2'd3
	} direction_t;

	// Walk cycle order
	typedef enum logic [1:0] {
		stepRest1 = 2'd0,
		stepMove1 = 2'd1,
		stepRest2 = 2'd2,
		stepMove2 = 2'd3
	} walkStep_t;

	typedef struct packed {
		logic moving;
		direction_t direction;
	} walkCmd_t;

	typedef struct packed {
		logic [CoordW-1:0] drawX;
		logic [CoordW-1:0] drawY;
		logic visible;
	} pixelPos_t;

	typedef struct packed {
		logic up;
		logic left;
		logic down;
		logic right;
	} blockFlags_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		logic signed [CamW-1:0] camX;
		logic signed [CamW-1:0] camY;
	} camera_t;

	typedef struct packed {
		logic inMap;
		logic inSprite;
		logic visible;
	} stageFlags_t;

	// Index 0 is see-through
	localparam rgb_t spritePalette [16] = '{
		24'h000000, 24'hf8f8f8, 24'h101010, 24'hf0b080,
		24'hd07048, 24'he02828, 24'h901818, 24'h2858d0,
		24'h183890, 24'h50a040, 24'h306828, 24'hf8d848,
		24'ha07828, 24'h604020, 24'h909098, 24'h505058
	};

	function automatic int unsigned sheetColumn(direction_t dir, walkStep_t stp);
		int unsigned base;
		int unsigned offs;
		case (dir)
			dirDown: base = 0;
			dirLeft: base = 57;
			dirUp: base = 114;
			default: base = 171;
		endcase
		case (stp)
			stepMove1: offs = 0;
			stepMove2: offs = 38;
			default: offs = 19;
		endcase
		return base + offs;
	endfunction

endpackage

`default_nettype wire

/* source/walkController.sv */
`timescale 1ns/1ps
`default_nettype none

module walkController #(
	parameter int MapW = mapperPkg::MapW,
	parameter int SpriteX0 = mapperPkg::SpriteX0,
	parameter int SpriteY0 = mapperPkg::SpriteY0,
	parameter int CamStartX = mapperPkg::CamStartX,
	parameter int CamStartY = mapperPkg::CamStartY,
	parameter int StepDelay = mapperPkg::StepDelay
) (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input mapperPkg::walkCmd_t walk,
	input mapperPkg::blockFlags_t collisionData,
	output mapperPkg::camera_t camera,
	output mapperPkg::direction_t facing,
	output mapperPkg::walkStep_t step,
	output logic [mapperPkg::MapAddrW-1:0] collisionAddr
);
	import mapperPkg::*;

	localparam int DelayW = (StepDelay > 1) ? $clog2(StepDelay) : 1;

	logic [DelayW-1:0] delayCnt;
	logic [1:0] stepNext;
	logic signed [CamW:0] charX;
	logic signed [CamW:0] charY;
	logic signed [CamW:0] tileX;
	logic signed [CamW:0] tileY;
	logic canUp;
	logic canDown;
	logic canLeft;
	logic canRight;

	// Character sits at a fixed offset from the camera
	always_comb begin
		charX = camera.camX + (CamW + 1)'(SpriteX0);
		charY = camera.camY + (CamW + 1)'(SpriteY0);
		tileX = charX >>> TexelShift;
		tileY = charY >>> TexelShift;
		collisionAddr = MapAddrW'(tileY * MapW + tileX);
	end

	// Bounds and blocking per direction
	always_comb begin
		canUp = (camera.camY > CamMinY) && !collisionData.up;
		canDown = (camera.camY <= CamMaxY) && !collisionData.down;
		canLeft = (camera.camX > CamMinX) && !collisionData.left;
		canRight = (camera.camX <= CamMaxX) && !collisionData.right;
	end

	assign stepNext = step + 2'd1;

	always_ff @(posedge Clk) begin
		if (rst) begin
			camera.camX <= CamW'(CamStartX);
			camera.camY <= CamW'(CamStartY);
			facing <= dirUp;
			step <= stepRest1;
			delayCnt <= '0;
		end else if (frameTick) begin
			if (!walk.moving) begin
				step <= stepRest1;
			end else if (walk.direction != facing) begin
				// Turn in place first
				facing <= walk.direction;
				step <= stepRest1;
			end else begin
				if (delayCnt == '0) begin
					step <= walkStep_t'(stepNext);
				end
				if (delayCnt == DelayW'(StepDelay - 1)) begin
					delayCnt <= '0;
				end else begin
					delayCnt <= delayCnt + 1'b1;
				end
				case (facing)
					dirUp: begin
						if (canUp) begin
							camera.camY <= camera.camY - 1'b1;
						end
					end
					dirDown: begin
						if (canDown) begin
							camera.camY <= camera.camY + 1'b1;
						end
					end
					dirLeft: begin
						if (canLeft) begin
							camera.camX <= camera.camX - 1'b1;
						end
					end
					default: begin
						if (canRight) begin
							camera.camX <= camera.camX + 1'b1;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/sceneAddress.sv */
`timescale 1ns/1ps
`default_nettype none

module sceneAddress #(
	parameter int MapW = mapperPkg::MapW,
	parameter int MapH = mapperPkg::MapH,
	parameter int SheetW = mapperPkg::SheetW,
	parameter int SpriteX0 = mapperPkg::SpriteX0,
	parameter int SpriteY0 = mapperPkg::SpriteY0
) (
	input logic Clk,
	input logic rst,
	input mapperPkg::pixelPos_t pixel,
	input mapperPkg::camera_t camera,
	input mapperPkg::direction_t facing,
	input mapperPkg::walkStep_t step,
	output logic [mapperPkg::MapAddrW-1:0] mapAddr,
	output logic [mapperPkg::SpriteAddrW-1:0] spriteAddr,
	output mapperPkg::stageFlags_t stageFlags
);
	import mapperPkg::*;

	logic signed [CamW:0] worldX;
	logic signed [CamW:0] worldY;
	logic signed [CamW:0] texelX;
	logic signed [CamW:0] texelY;
	logic [CoordW-1:0] relX;
	logic [CoordW-1:0] relY;
	logic inMap;
	logic inSprite;
	logic [MapAddrW-1:0] mapAddrNext;
	logic [SpriteAddrW-1:0] spriteAddrNext;

	// Screen to world, then world to texel
	always_comb begin
		worldX = $signed({3'b000, pixel.drawX}) + camera.camX;
		worldY = $signed({3'b000, pixel.drawY}) + camera.camY;
		texelX = worldX >>> TexelShift;
		texelY = worldY >>> TexelShift;
		inMap = (worldX >= 0) && (worldY >= 0) && (texelX < MapW) && (texelY < MapH);
		if (inMap) begin
			mapAddrNext = MapAddrW'(texelY * MapW + texelX);
		end else begin
			mapAddrNext = '0;
		end
	end

	// Character window and sheet lookup
	always_comb begin
		relX = pixel.drawX - CoordW'(SpriteX0);
		relY = pixel.drawY - CoordW'(SpriteY0);
		inSprite = (pixel.drawX >= SpriteX0) && (pixel.drawX < SpriteX0 + SpriteW)
			&& (pixel.drawY >= SpriteY0) && (pixel.drawY < SpriteY0 + SpriteH);
		if (inSprite) begin
			spriteAddrNext = SpriteAddrW'(SheetW * relY + relX + sheetColumn(facing, step));
		end else begin
			spriteAddrNext = '0;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			mapAddr <= '0;
			spriteAddr <= '0;
			stageFlags <= '0;
		end else begin
			mapAddr <= mapAddrNext;
			spriteAddr <= spriteAddrNext;
			stageFlags.inMap <= inMap;
			stageFlags.inSprite <= inSprite;
			stageFlags.visible <= pixel.visible;
		end
	end

endmodule

`default_nettype wire

/* source/pixelCompositor.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelCompositor (
	input logic Clk,
	input logic rst,
	input mapperPkg::stageFlags_t stageFlags,
	input logic [7:0] mapData,
	input logic [3:0] spriteData,
	output mapperPkg::rgb_t rgb
);
	import mapperPkg::*;

	stageFlags_t flagsD;
	rgb_t mapColor;
	rgb_t rgbNext;

	// Memories answer one cycle later
	always_ff @(posedge Clk) begin
		if (rst) begin
			flagsD <= '0;
		end else begin
			flagsD <= stageFlags;
		end
	end

	// RGB332 widened by repeating the top bits
	always_comb begin
		mapColor.red = {mapData[7:5], mapData[7:5], mapData[7:6]};
		mapColor.green = {mapData[4:2], mapData[4:2], mapData[4:3]};
		mapColor.blue = {4{mapData[1:0]}};
	end

	always_comb begin
		if (!flagsD.visible || !flagsD.inMap) begin
			rgbNext = '0;
		end else if (flagsD.inSprite && (spriteData != 4'd0)) begin
			rgbNext = spritePalette[spriteData];
		end else begin
			rgbNext = mapColor;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			rgb <= '0;
		end else begin
			rgb <= rgbNext;
		end
	end

endmodule

`default_nettype wire

/* source/colorMapperTop.sv */
`timescale 1ns/1ps
`default_nettype none

module colorMapperTop #(
	parameter int MapW = mapperPkg::MapW,
	parameter int MapH = mapperPkg::MapH,
	parameter int SheetW = mapperPkg::SheetW,
	parameter int SpriteX0 = mapperPkg::SpriteX0,
	parameter int SpriteY0 = mapperPkg::SpriteY0,
	parameter int CamStartX = mapperPkg::CamStartX,
	parameter int CamStartY = mapperPkg::CamStartY,
	parameter int StepDelay = mapperPkg::StepDelay
) (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input mapperPkg::walkCmd_t walk,
	input mapperPkg::pixelPos_t pixel,
	output logic [mapperPkg::MapAddrW-1:0] mapAddr,
	input logic [7:0] mapData,
	output logic [mapperPkg::SpriteAddrW-1:0] spriteAddr,
	input logic [3:0] spriteData,
	output logic [mapperPkg::MapAddrW-1:0] collisionAddr,
	input mapperPkg::blockFlags_t collisionData,
	output mapperPkg::rgb_t rgb
);
	import mapperPkg::*;

	camera_t camera;
	direction_t facing;
	walkStep_t step;
	stageFlags_t stageFlags;

	walkController #(
		.MapW(MapW),
		.SpriteX0(SpriteX0),
		.SpriteY0(SpriteY0),
		.CamStartX(CamStartX),
		.CamStartY(CamStartY),
		.StepDelay(StepDelay)
	) walk0 (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.walk(walk),
		.collisionData(collisionData),
		.camera(camera),
		.facing(facing),
		.step(step),
		.collisionAddr(collisionAddr)
	);

	// Stage 1 addresses, stages 2 and 3 colour
	sceneAddress #(
		.MapW(MapW),
		.MapH(MapH),
		.SheetW(SheetW),
		.SpriteX0(SpriteX0),
		.SpriteY0(SpriteY0)
	) scene0 (
		.Clk(Clk),
		.rst(rst),
		.pixel(pixel),
		.camera(camera),
		.facing(facing),
		.step(step),
		.mapAddr(mapAddr),
		.spriteAddr(spriteAddr),
		.stageFlags(stageFlags)
	);

	pixelCompositor comp0 (
		.Clk(Clk),
		.rst(rst),
		.stageFlags(stageFlags),
		.mapData(mapData),
		.spriteData(spriteData),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* dv/videoMemModel.sv */
`timescale 1ns/1ps
`default_nettype none

module videoMemModel #(
	parameter int MapW = mapperPkg::MapW,
	parameter int BlockCol = 104
) (
	input logic Clk,
	input logic [mapperPkg::MapAddrW-1:0] mapAddr,
	output logic [7:0] mapData,
	input logic [mapperPkg::SpriteAddrW-1:0] spriteAddr,
	output logic [3:0] spriteData,
	input logic [mapperPkg::MapAddrW-1:0] collisionAddr,
	output mapperPkg::blockFlags_t collisionData
);
	import mapperPkg::*;

	// Rule-based contents with one-cycle read latency
	always_ff @(posedge Clk) begin
		mapData <= 8'(mapAddr ^ (mapAddr >> 8));
		spriteData <= 4'(spriteAddr * 7);
		// Wall to the right of tile column BlockCol
		collisionData <= '{
			up: 1'b0,
			left: 1'b0,
			down: 1'b0,
			right: ((collisionAddr % MapW) >= BlockCol)
		};
	end

endmodule

`default_nettype wire

/* dv/pixelChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelChecker #(
	parameter int BlockCol = 104
) (
	input logic Clk,
	input logic rst,
	input logic frameTick,
	input mapperPkg::walkCmd_t walk,
	input mapperPkg::pixelPos_t pixel,
	input logic tileCheck,
	input logic [mapperPkg::MapAddrW-1:0] tileExpected,
	input logic [mapperPkg::MapAddrW-1:0] collisionAddr,
	input logic [mapperPkg::MapAddrW-1:0] mapAddr,
	input logic [mapperPkg::SpriteAddrW-1:0] spriteAddr,
	input mapperPkg::rgb_t rgb,
	output int errCount,
	output int checkCount
);
	import mapperPkg::*;

	// Sheet column parts by direction code and by step code
	localparam int groupBase [4] = '{114, 171, 0, 57};
	localparam int stepOffset [4] = '{19, 0, 19, 38};
	localparam int TexelSize = 1 << TexelShift;

	int camX;
	int camY;
	int facing;
	int step;
	int delay;
	logic [3:1] valid;
	int expMap;
	int expSpr;
	rgb_t expRgb [1:3];

	initial begin
		errCount = 0;
		checkCount = 0;
	end

	task automatic compareValue(input string what, input logic [31:0] got,
			input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
		end
	endtask

	function automatic rgb_t widen332(input logic [7:0] c);
		rgb_t w;
		int r;
		int g;
		int b;
		r = c[7:5];
		g = c[4:2];
		b = c[1:0];
		w.red = 8'((r << 5) | (r << 2) | (r >> 1));
		w.green = 8'((g << 5) | (g << 2) | (g >> 1));
		w.blue = 8'(b * 85);
		return w;
	endfunction

	task automatic predictPixel(input pixelPos_t p, output int eMap, output int eSpr,
			output rgb_t eRgb);
		int px;
		int py;
		int wx;
		int wy;
		int idx;
		logic inMap;
		logic inSpr;
		logic [7:0] texel;
		px = p.drawX;
		py = p.drawY;
		wx = px + camX;
		wy = py + camY;
		inMap = (wx >= 0) && (wy >= 0) && (wx < MapW * TexelSize) && (wy < MapH * TexelSize);
		eMap = inMap ? (wy / TexelSize) * MapW + wx / TexelSize : 0;
		inSpr = (px >= SpriteX0) && (px < SpriteX0 + SpriteW)
			&& (py >= SpriteY0) && (py < SpriteY0 + SpriteH);
		eSpr = inSpr ? SheetW * (py - SpriteY0) + (px - SpriteX0)
			+ groupBase[facing] + stepOffset[step] : 0;
		texel = 8'((eMap % 256) ^ ((eMap / 256) % 256));
		idx = (eSpr * 7) % 16;
		if (!p.visible || !inMap) begin
			eRgb = '0;
		end else if (inSpr && idx != 0) begin
			eRgb = spritePalette[idx];
		end else begin
			eRgb = widen332(texel);
		end
	endtask

	// One frame tick of the walking rules
	task automatic advanceModel();
		if (!walk.moving) begin
			step = 0;
		end else if (int'(walk.direction) != facing) begin
			facing = walk.direction;
			step = 0;
		end else begin
			if (delay == 0) begin
				step = (step + 1) % 4;
			end
			delay = (delay + 1) % StepDelay;
			case (facing)
				0: camY = (camY > CamMinY) ? camY - 1 : camY;
				2: camY = (camY <= CamMaxY) ? camY + 1 : camY;
				3: camX = (camX > CamMinX) ? camX - 1 : camX;
				default: begin
					if (camX <= CamMaxX && (camX + SpriteX0) / TexelSize < BlockCol) begin
						camX = camX + 1;
					end
				end
			endcase
		end
	endtask

	// Inputs here are what the DUT takes at the next rising edge
	always @(negedge Clk) begin : sampleBlock
		int eMap;
		int eSpr;
		rgb_t eRgb;
		if (rst) begin
			camX = CamStartX;
			camY = CamStartY;
			facing = 0;
			step = 0;
			delay = 0;
			valid = '0;
			compareValue("rgb in reset", rgb, 0);
			compareValue("mapAddr in reset", mapAddr, 0);
			compareValue("spriteAddr in reset", spriteAddr, 0);
		end else begin
			compareValue("collisionAddr", collisionAddr,
				((camY + SpriteY0) / TexelSize) * MapW + (camX + SpriteX0) / TexelSize);
			if (tileCheck) begin
				compareValue("collisionAddr at phase end", collisionAddr, tileExpected);
			end
			if (valid[1]) begin
				compareValue("mapAddr", mapAddr, expMap);
				compareValue("spriteAddr", spriteAddr, expSpr);
			end
			if (valid[3]) begin
				compareValue("rgb", rgb, expRgb[3]);
			end
			valid[3] = valid[2];
			valid[2] = valid[1];
			expRgb[3] = expRgb[2];
			expRgb[2] = expRgb[1];
			predictPixel(pixel, eMap, eSpr, eRgb);
			valid[1] = 1'b1;
			expMap = eMap;
			expSpr = eSpr;
			expRgb[1] = eRgb;
			if (frameTick) begin
				advanceModel();
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tbColorMapper.sv */
`timescale 1ns/1ps
`default_nettype none

module tbColorMapper;
	import mapperPkg::*;

	typedef struct packed {
		logic moving;
		direction_t direction;
		logic [15:0] ticks;
		logic [15:0] pixels;
		logic [15:0] tileCol;
		logic [15:0] tileRow;
	} phase_t;

	localparam int PhaseCount = 10;
	localparam int TickSpacing = 4;
	localparam int ResetCycles = 4;
	localparam int DrainCycles = 8;
	localparam int BlockCol = 104;

	// Walk command, frame ticks, pixel scan and the character tile after the ticks
	localparam phase_t phaseTable [PhaseCount] = '{
		'{1'b0, dirUp, 16'd0, 16'd300, 16'd102, 16'd110},
		'{1'b1, dirRight, 16'd12, 16'd150, 16'd104, 16'd110},
		'{1'b1, dirLeft, 16'd420, 16'd150, 16'd0, 16'd110},
		'{1'b1, dirDown, 16'd1, 16'd100, 16'd0, 16'd110},
		'{1'b1, dirDown, 16'd5, 16'd100, 16'd0, 16'd111},
		'{1'b1, dirDown, 16'd8, 16'd100, 16'd0, 16'd113},
		'{1'b1, dirDown, 16'd8, 16'd100, 16'd0, 16'd115},
		'{1'b1, dirUp, 16'd1, 16'd100, 16'd0, 16'd115},
		'{1'b1, dirUp, 16'd3, 16'd100, 16'd0, 16'd114},
		'{1'b0, dirUp, 16'd2, 16'd150, 16'd0, 16'd114}
	};

	logic Clk = 1'b0;
	logic rst;
	logic frameTick;
	walkCmd_t walk;
	pixelPos_t pixel;
	logic [MapAddrW-1:0] mapAddr;
	logic [7:0] mapData;
	logic [SpriteAddrW-1:0] spriteAddr;
	logic [3:0] spriteData;
	logic [MapAddrW-1:0] collisionAddr;
	blockFlags_t collisionData;
	rgb_t rgb;
	logic tileCheck;
	logic [MapAddrW-1:0] tileExpected;
	int errCount;
	int checkCount;

	always #5 Clk = ~Clk;

	colorMapperTop #(
		.MapW(MapW),
		.MapH(MapH),
		.SheetW(SheetW),
		.StepDelay(StepDelay)
	) dut0 (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.walk(walk),
		.pixel(pixel),
		.mapAddr(mapAddr),
		.mapData(mapData),
		.spriteAddr(spriteAddr),
		.spriteData(spriteData),
		.collisionAddr(collisionAddr),
		.collisionData(collisionData),
		.rgb(rgb)
	);

	videoMemModel #(.MapW(MapW), .BlockCol(BlockCol)) mem0 (
		.Clk(Clk),
		.mapAddr(mapAddr),
		.mapData(mapData),
		.spriteAddr(spriteAddr),
		.spriteData(spriteData),
		.collisionAddr(collisionAddr),
		.collisionData(collisionData)
	);

	pixelChecker #(.BlockCol(BlockCol)) check0 (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.walk(walk),
		.pixel(pixel),
		.tileCheck(tileCheck),
		.tileExpected(tileExpected),
		.collisionAddr(collisionAddr),
		.mapAddr(mapAddr),
		.spriteAddr(spriteAddr),
		.rgb(rgb),
		.errCount(errCount),
		.checkCount(checkCount)
	);

	function automatic int totalCycles();
		int sum;
		sum = ResetCycles + DrainCycles + 1;
		for (int i = 0; i < PhaseCount; i++) begin
			sum += 1 + TickSpacing * phaseTable[i].ticks + phaseTable[i].pixels;
		end
		return sum;
	endfunction

	// Half the draws land in the character window
	function automatic pixelPos_t randomPixel();
		pixelPos_t p;
		if ($urandom % 2 == 0) begin
			p.drawX = CoordW'(SpriteX0 + $urandom % SpriteW);
			p.drawY = CoordW'(SpriteY0 + $urandom % SpriteH);
		end else begin
			p.drawX = CoordW'($urandom % 1400);
			p.drawY = CoordW'($urandom % 1100);
		end
		p.visible = ($urandom % 8) != 0;
		return p;
	endfunction

	task automatic runPhase(input phase_t ph);
		@(posedge Clk);
		walk <= '{moving: ph.moving, direction: ph.direction};
		tileCheck <= 1'b0;
		tileExpected <= MapAddrW'(ph.tileRow * MapW + ph.tileCol);
		for (int t = 0; t < ph.ticks; t++) begin
			@(posedge Clk);
			frameTick <= 1'b1;
			@(posedge Clk);
			frameTick <= 1'b0;
			repeat (TickSpacing - 2) @(posedge Clk);
		end
		for (int p = 0; p < ph.pixels; p++) begin
			@(posedge Clk);
			pixel <= randomPixel();
			tileCheck <= (p == 0);
		end
	endtask

	initial begin : stimulus
		void'($urandom(44530));
		rst = 1'b1;
		frameTick = 1'b0;
		walk = '0;
		pixel = '0;
		tileCheck = 1'b0;
		tileExpected = '0;
		repeat (ResetCycles) @(posedge Clk);
		rst <= 1'b0;
		for (int i = 0; i < PhaseCount; i++) begin
			runPhase(phaseTable[i]);
		end
		@(posedge Clk);
		pixel <= '0;
		tileCheck <= 1'b0;
		repeat (DrainCycles) @(posedge Clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0 && checkCount > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = 2 * totalCycles();
		repeat (limit) @(posedge Clk);
		$display("Watchdog expired: the run did not finish within %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
source/mapperPkg.sv
source/walkController.sv
source/sceneAddress.sv
source/pixelCompositor.sv
source/colorMapperTop.sv
dv/videoMemModel.sv
dv/pixelChecker.sv
dv/tbColorMapper.sv
